/* hdl/exe_pkg.sv */
package exe_pkg;

    // Datapath words and instruction fields
    typedef logic [31:0] word_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // RV32I major opcodes kept by this stage
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    localparam funct7_t FUNCT7_BASE = 7'b0000000;
    // SUB, SRA and SRAI
    localparam funct7_t FUNCT7_ALT  = 7'b0100000;

    // Conditional branch funct3
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // Load and store widths
    localparam funct3_t F3_MEM_B  = 3'b000;
    localparam funct3_t F3_MEM_H  = 3'b001;
    localparam funct3_t F3_MEM_W  = 3'b010;
    localparam funct3_t F3_MEM_BU = 3'b100;
    localparam funct3_t F3_MEM_HU = 3'b101;

    // Shared by OP and OP-IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SR      = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    typedef enum logic [3:0] {
        ALU_AND    = 4'b0000,
        ALU_OR     = 4'b0001,
        ALU_XOR    = 4'b0010,
        ALU_ADD    = 4'b0011,
        ALU_SUB    = 4'b0100,
        ALU_PASS_B = 4'b0110,
        ALU_SLL    = 4'b0111,
        ALU_SRL    = 4'b1000,
        ALU_SRA    = 4'b1010,
        ALU_SLTU   = 4'b1011,
        ALU_SLT    = 4'b1100
    } alu_op_e;

    typedef enum logic [3:0] {
        IMM_NONE = 4'd0,
        IMM_I    = 4'd1,
        IMM_S    = 4'd2,
        IMM_B    = 4'd3,
        IMM_U    = 4'd4,
        IMM_J    = 4'd5
    } imm_kind_e;

    // Pc redirect condition
    typedef enum logic [2:0] {
        BR_NONE   = 3'd0,
        BR_EQ     = 3'd1,
        BR_NE     = 3'd2,
        BR_LT     = 3'd3,
        BR_GE     = 3'd4,
        BR_ALWAYS = 3'd5
    } br_cond_e;

endpackage

/* hdl/exe_decoder.sv */
`timescale 1ns/1ps

module exe_decoder
    import exe_pkg::*;
(
    input  word_t     instruction,
    output logic      a_sel,
    output logic      b_sel,
    output imm_kind_e imm_sel,
    output alu_op_e   alu_sel,
    output logic      br_un,
    output br_cond_e  br_cond
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    is_reg;
    alu_op_e arith_op;
    logic    arith_ok;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign is_reg = (opcode == OPC_OP);

    // ALU operation for OP and OP-IMM
    always_comb begin
        arith_op = ALU_AND;
        arith_ok = 1'b0;
        case (funct3)
            F3_ADD_SUB: begin
                // Immediate form has no funct7, so ADDI is always ADD
                if (!is_reg || funct7 == FUNCT7_BASE) begin
                    arith_op = ALU_ADD;
                    arith_ok = 1'b1;
                end else if (funct7 == FUNCT7_ALT) begin
                    arith_op = ALU_SUB;
                    arith_ok = 1'b1;
                end
            end
            F3_SLL: begin
                arith_op = ALU_SLL;
                arith_ok = (funct7 == FUNCT7_BASE);
            end
            F3_SLT: begin
                arith_op = ALU_SLT;
                arith_ok = !is_reg || funct7 == FUNCT7_BASE;
            end
            F3_SLTU: begin
                arith_op = ALU_SLTU;
                arith_ok = !is_reg || funct7 == FUNCT7_BASE;
            end
            F3_XOR: begin
                arith_op = ALU_XOR;
                arith_ok = !is_reg || funct7 == FUNCT7_BASE;
            end
            F3_SR: begin
                if (funct7 == FUNCT7_BASE) begin
                    arith_op = ALU_SRL;
                    arith_ok = 1'b1;
                end else if (funct7 == FUNCT7_ALT) begin
                    arith_op = ALU_SRA;
                    arith_ok = 1'b1;
                end
            end
            F3_OR: begin
                arith_op = ALU_OR;
                arith_ok = !is_reg || funct7 == FUNCT7_BASE;
            end
            F3_AND: begin
                arith_op = ALU_AND;
                arith_ok = !is_reg || funct7 == FUNCT7_BASE;
            end
        endcase
    end

    always_comb begin
        a_sel   = 1'b0;
        b_sel   = 1'b0;
        imm_sel = IMM_NONE;
        alu_sel = ALU_AND;
        br_un   = 1'b0;
        br_cond = BR_NONE;

        case (opcode)
            OPC_LUI: begin
                b_sel   = 1'b1;
                imm_sel = IMM_U;
                alu_sel = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                a_sel   = 1'b1;
                b_sel   = 1'b1;
                imm_sel = IMM_U;
                alu_sel = ALU_ADD;
            end
            OPC_JAL: begin
                a_sel   = 1'b1;
                b_sel   = 1'b1;
                imm_sel = IMM_J;
                alu_sel = ALU_ADD;
                br_cond = BR_ALWAYS;
            end
            OPC_JALR: begin
                b_sel   = 1'b1;
                imm_sel = IMM_I;
                alu_sel = ALU_ADD;
                br_cond = BR_ALWAYS;
            end
            OPC_BRANCH: begin
                // Target is pc plus the B immediate
                if (funct3 == F3_BEQ || funct3 == F3_BNE || funct3 == F3_BLT ||
                    funct3 == F3_BGE || funct3 == F3_BLTU || funct3 == F3_BGEU) begin
                    a_sel   = 1'b1;
                    b_sel   = 1'b1;
                    imm_sel = IMM_B;
                    alu_sel = ALU_ADD;
                    br_un   = (funct3 == F3_BLTU || funct3 == F3_BGEU);
                    case (funct3)
                        F3_BEQ:          br_cond = BR_EQ;
                        F3_BNE:          br_cond = BR_NE;
                        F3_BLT, F3_BLTU: br_cond = BR_LT;
                        default:         br_cond = BR_GE;
                    endcase
                end
            end
            OPC_LOAD: begin
                if (funct3 == F3_MEM_B || funct3 == F3_MEM_H || funct3 == F3_MEM_W ||
                    funct3 == F3_MEM_BU || funct3 == F3_MEM_HU) begin
                    b_sel   = 1'b1;
                    imm_sel = IMM_I;
                    alu_sel = ALU_ADD;
                end
            end
            OPC_STORE: begin
                if (funct3 == F3_MEM_B || funct3 == F3_MEM_H || funct3 == F3_MEM_W) begin
                    b_sel   = 1'b1;
                    imm_sel = IMM_S;
                    alu_sel = ALU_ADD;
                end
            end
            OPC_OP_IMM, OPC_OP: begin
                if (arith_ok) begin
                    b_sel   = !is_reg;
                    imm_sel = is_reg ? IMM_NONE : IMM_I;
                    alu_sel = arith_op;
                end
            end
            default: begin
                // FENCE, SYSTEM and unknown opcodes keep the defaults
            end
        endcase
    end

endmodule

/* hdl/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit
    import exe_pkg::*;
(
    input  word_t    data_a,
    input  word_t    data_b,
    input  br_cond_e br_cond,
    input  logic     br_un,
    output logic     take
);

    logic eq;
    logic lt;
    logic lt_signed;
    logic lt_unsigned;

    assign eq          = (data_a == data_b);
    assign lt_unsigned = (data_a < data_b);
    assign lt_signed   = ($signed(data_a) < $signed(data_b));
    assign lt          = br_un ? lt_unsigned : lt_signed;

    always_comb begin
        case (br_cond)
            BR_ALWAYS: take = 1'b1;
            BR_EQ:     take = eq;
            BR_NE:     take = !eq;
            BR_LT:     take = lt;
            // GE is the complement of LT
            BR_GE:     take = !lt;
            default:   take = 1'b0;
        endcase
    end

endmodule

/* hdl/execute_ctl.sv */
`timescale 1ns/1ps

module execute_ctl
    import exe_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  word_t     instruction,
    input  word_t     pc,
    input  word_t     data_a,
    input  word_t     data_b,
    output logic      a_sel,
    output logic      b_sel,
    output imm_kind_e imm_sel,
    output alu_op_e   alu_sel,
    output logic      br_un,
    output logic      pc_sel,
    output word_t     pc_exe,
    output word_t     instr_exe,
    output word_t     data_a_exe,
    output word_t     data_b_exe
);

    logic      a_sel_d;
    logic      b_sel_d;
    imm_kind_e imm_sel_d;
    alu_op_e   alu_sel_d;
    logic      br_un_d;
    br_cond_e  br_cond_d;
    logic      take_d;

    exe_decoder i_exe_decoder (
        .instruction (instruction),
        .a_sel       (a_sel_d),
        .b_sel       (b_sel_d),
        .imm_sel     (imm_sel_d),
        .alu_sel     (alu_sel_d),
        .br_un       (br_un_d),
        .br_cond     (br_cond_d)
    );

    // Operands come straight from decode, same cycle as the instruction
    branch_unit i_branch_unit (
        .data_a  (data_a),
        .data_b  (data_b),
        .br_cond (br_cond_d),
        .br_un   (br_un_d),
        .take    (take_d)
    );

    // Execute stage register, one instruction per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_sel      <= 1'b0;
            b_sel      <= 1'b1;
            imm_sel    <= IMM_NONE;
            alu_sel    <= ALU_PASS_B;
            br_un      <= 1'b0;
            pc_sel     <= 1'b0;
            pc_exe     <= '0;
            instr_exe  <= '0;
            data_a_exe <= '0;
            data_b_exe <= '0;
        end else begin
            a_sel      <= a_sel_d;
            b_sel      <= b_sel_d;
            imm_sel    <= imm_sel_d;
            alu_sel    <= alu_sel_d;
            br_un      <= br_un_d;
            pc_sel     <= take_d;
            pc_exe     <= pc;
            instr_exe  <= instruction;
            data_a_exe <= data_a;
            data_b_exe <= data_b;
        end
    end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 50;
    localparam int RESET_CYCLES = 2;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Released on a rising edge, like any other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* testbench/execute_ctl_assertions.sv */
`timescale 1ns/1ps

module execute_ctl_assertions
    import exe_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       a_sel,
    input logic       b_sel,
    input logic [3:0] imm_sel,
    input logic [3:0] alu_sel,
    input logic       br_un,
    input logic       pc_sel,
    input word_t      pc_exe,
    input word_t      instr_exe,
    input word_t      data_a_exe,
    input word_t      data_b_exe
);

    int fail_count = 0;

    // Falling edge keeps the samples away from register updates
    reset_controls: assert property (@(negedge clk) rst |->
        (!a_sel && b_sel && imm_sel == IMM_NONE && alu_sel == ALU_PASS_B && !br_un && !pc_sel))
        else begin
            fail_count++;
            $error("control outputs are not at their reset values while rst is high");
        end

    reset_words: assert property (@(negedge clk) rst |->
        (pc_exe == '0 && instr_exe == '0 && data_a_exe == '0 && data_b_exe == '0))
        else begin
            fail_count++;
            $error("stage words are not zero while rst is high");
        end

    imm_legal: assert property (@(negedge clk)
        imm_sel inside {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J})
        else begin
            fail_count++;
            $error("imm_sel holds an undefined immediate format");
        end

    alu_legal: assert property (@(negedge clk)
        alu_sel inside {ALU_AND, ALU_OR, ALU_XOR, ALU_ADD, ALU_SUB, ALU_PASS_B,
                        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLTU, ALU_SLT})
        else begin
            fail_count++;
            $error("alu_sel holds an undefined ALU operation");
        end

endmodule

/* testbench/execute_ctl_tb.sv */
`timescale 1ns/1ps

module execute_ctl_tb
    import exe_pkg::*;
();

    localparam int N_ARITH  = 300;
    localparam int N_FIXED  = 200;
    localparam int N_BRANCH = 300;
    localparam int N_UNDEF  = 200;
    localparam int N_STREAM = 500;
    // Reset phase plus one flush cycle per random test
    localparam int TEST_CYCLES = 4 + N_ARITH + N_FIXED + N_BRANCH + N_UNDEF + N_STREAM + 5;
    localparam int MAX_CYCLES  = TEST_CYCLES + 100;
    localparam logic [10:0] DEFAULT_CTL = {1'b0, 1'b0, IMM_NONE, ALU_AND, 1'b0};

    logic      clk;
    logic      rst;
    word_t     instruction;
    word_t     pc;
    word_t     data_a;
    word_t     data_b;
    logic      a_sel;
    logic      b_sel;
    imm_kind_e imm_sel;
    alu_op_e   alu_sel;
    logic      br_un;
    logic      pc_sel;
    word_t     pc_exe;
    word_t     instr_exe;
    word_t     data_a_exe;
    word_t     data_b_exe;

    word_t       rng_state = 32'd49105;
    word_t       pc_now;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          errors_at_start = 0;
    int          test_num = 0;
    int          tests_failed = 0;
    int          assert_fails = 0;
    logic        have_prev = 1'b0;
    // Packed as {a_sel, b_sel, imm_sel, alu_sel, br_un}
    logic [10:0] exp_ctl;
    logic        exp_take;
    word_t       exp_pc;
    word_t       exp_instr;
    word_t       exp_a;
    word_t       exp_b;

    tb_clock i_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    execute_ctl i_execute_ctl (.*);

    bind execute_ctl execute_ctl_assertions i_execute_ctl_assertions (
        .clk        (clk),
        .rst        (rst),
        .a_sel      (a_sel),
        .b_sel      (b_sel),
        .imm_sel    (imm_sel),
        .alu_sel    (alu_sel),
        .br_un      (br_un),
        .pc_sel     (pc_sel),
        .pc_exe     (pc_exe),
        .instr_exe  (instr_exe),
        .data_a_exe (data_a_exe),
        .data_b_exe (data_b_exe)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic word_t xorshift32(word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function word_t next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Returns {legal, alu op} for the OP and OP-IMM groups
    function automatic logic [4:0] arith_model(logic reg_form, funct3_t f3, funct7_t f7);
        logic plain;
        plain = (f7 == 7'b0000000);
        case (f3)
            3'b000: begin
                if (!reg_form || plain) return {1'b1, ALU_ADD};
                if (f7 == 7'b0100000) return {1'b1, ALU_SUB};
            end
            3'b001: if (plain) return {1'b1, ALU_SLL};
            3'b101: begin
                if (plain) return {1'b1, ALU_SRL};
                if (f7 == 7'b0100000) return {1'b1, ALU_SRA};
            end
            default: begin
                if (!reg_form || plain) begin
                    case (f3)
                        3'b010:  return {1'b1, ALU_SLT};
                        3'b011:  return {1'b1, ALU_SLTU};
                        3'b100:  return {1'b1, ALU_XOR};
                        3'b110:  return {1'b1, ALU_OR};
                        default: return {1'b1, ALU_AND};
                    endcase
                end
            end
        endcase
        return {1'b0, ALU_AND};
    endfunction

    function automatic logic [10:0] decode_model(word_t instr);
        funct3_t    f3;
        logic [4:0] ar;
        f3 = instr[14:12];
        case (instr[6:0])
            OPC_LUI:   return {1'b0, 1'b1, IMM_U, ALU_PASS_B, 1'b0};
            OPC_AUIPC: return {1'b1, 1'b1, IMM_U, ALU_ADD, 1'b0};
            OPC_JAL:   return {1'b1, 1'b1, IMM_J, ALU_ADD, 1'b0};
            OPC_JALR:  return {1'b0, 1'b1, IMM_I, ALU_ADD, 1'b0};
            OPC_BRANCH: begin
                // funct3 bit 1 marks BLTU and BGEU
                if (f3 != 3'b010 && f3 != 3'b011) return {1'b1, 1'b1, IMM_B, ALU_ADD, f3[1]};
            end
            OPC_LOAD: begin
                if (f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101})
                    return {1'b0, 1'b1, IMM_I, ALU_ADD, 1'b0};
            end
            OPC_STORE: if (f3 <= 3'b010) return {1'b0, 1'b1, IMM_S, ALU_ADD, 1'b0};
            OPC_OP_IMM: begin
                ar = arith_model(1'b0, f3, instr[31:25]);
                if (ar[4]) return {1'b0, 1'b1, IMM_I, ar[3:0], 1'b0};
            end
            OPC_OP: begin
                ar = arith_model(1'b1, f3, instr[31:25]);
                if (ar[4]) return {1'b0, 1'b0, IMM_NONE, ar[3:0], 1'b0};
            end
            default: ;
        endcase
        return DEFAULT_CTL;
    endfunction

    function automatic logic branch_model(word_t instr, word_t a, word_t b);
        if (instr[6:0] == OPC_JAL || instr[6:0] == OPC_JALR) return 1'b1;
        if (instr[6:0] != OPC_BRANCH) return 1'b0;
        case (instr[14:12])
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t with_fields(word_t w, opcode_t opc, funct3_t f3, funct7_t f7);
        return {f7, w[24:15], f3, w[11:7], opc};
    endfunction

    function automatic word_t gen_arith();
        word_t   w;
        funct3_t f3;
        funct7_t f7;
        w = next_rand();
        f3 = w[14:12];
        f7 = w[31:25];
        if ((f3 == 3'b000 && w[0]) || f3 == 3'b101) f7 = w[1] ? FUNCT7_ALT : FUNCT7_BASE;
        else if (f3 == 3'b001 || w[0]) f7 = FUNCT7_BASE;
        return with_fields(w, w[0] ? OPC_OP : OPC_OP_IMM, f3, f7);
    endfunction

    function automatic word_t gen_fixed();
        word_t   w;
        funct3_t f3;
        w = next_rand();
        f3 = w[14:12];
        case (w[2:0])
            3'd0, 3'd1: begin
                if (f3 == 3'b011 || f3[2:1] == 2'b11) f3 = 3'b010;
                return with_fields(w, OPC_LOAD, f3, w[31:25]);
            end
            3'd2:    return with_fields(w, OPC_STORE, f3 % 3'd3, w[31:25]);
            3'd3:    return with_fields(w, OPC_LUI, f3, w[31:25]);
            3'd4:    return with_fields(w, OPC_AUIPC, f3, w[31:25]);
            3'd5:    return with_fields(w, OPC_JAL, f3, w[31:25]);
            default: return with_fields(w, OPC_JALR, f3, w[31:25]);
        endcase
    endfunction

    function automatic word_t gen_branch();
        word_t   w;
        funct3_t f3;
        w = next_rand();
        f3 = w[14:12];
        if (f3[2:1] == 2'b01) f3 = {1'b1, f3[1:0]};
        return with_fields(w, OPC_BRANCH, f3, w[31:25]);
    endfunction

    function automatic word_t gen_undef();
        word_t   w;
        funct3_t f3;
        funct7_t f7;
        w = next_rand();
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[2:0])
            // No kept opcode ends in 000
            3'd0: return w;
            3'd1: return with_fields(w, w[3] ? 7'b1110011 : 7'b0001111, f3, f7);
            3'd2: return with_fields(w, OPC_BRANCH, {2'b01, f3[0]}, f7);
            3'd3: begin
                if (f3 != 3'b110 && f3 != 3'b111) f3 = 3'b011;
                return with_fields(w, OPC_LOAD, f3, f7);
            end
            3'd4: begin
                if (f3 <= 3'b010) f3 = f3 + 3'b101;
                return with_fields(w, OPC_STORE, f3, f7);
            end
            3'd5: begin
                if (f7 == FUNCT7_BASE) f7 = 7'b0000001;
                else if (f7 == FUNCT7_ALT && (f3 == 3'b000 || f3 == 3'b101)) f7 = 7'b0100001;
                return with_fields(w, OPC_OP, f3, f7);
            end
            3'd6: return with_fields(w, OPC_OP_IMM, 3'b001, f7 | 7'b0000100);
            default: begin
                if (f7 == FUNCT7_BASE || f7 == FUNCT7_ALT) f7 = f7 | 7'b0010000;
                return with_fields(w, OPC_OP_IMM, 3'b101, f7);
            end
        endcase
    endfunction

    function automatic word_t gen_mixed();
        word_t r;
        r = next_rand();
        case (r[2:0])
            3'd0:       return next_rand();
            3'd1, 3'd2: return gen_arith();
            3'd3, 3'd4: return gen_fixed();
            3'd5, 3'd6: return gen_branch();
            default:    return gen_undef();
        endcase
    endfunction

    task automatic pick_operands(input logic stress, output word_t a, output word_t b);
        word_t    r;
        logic [2:0] kind;
        r = next_rand();
        a = next_rand();
        b = next_rand();
        kind = (stress || r[7:3] < 5'd4) ? r[2:0] : 3'd7;
        case (kind)
            3'd0: b = a;
            3'd1: begin
                a = 32'h7fff_ffff;
                b = 32'h8000_0000;
            end
            3'd2: begin
                a = 32'h0000_0000;
                b = 32'hffff_ffff;
            end
            3'd3: b = a + 32'd1;
            default: ;
        endcase
        if (r[8]) {a, b} = {b, a};
    endtask

    task automatic check_value(input string name, input word_t got, input word_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("ERROR at time %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic check_reset_outputs();
        check_value("a_sel", 32'(a_sel), 32'd0);
        check_value("b_sel", 32'(b_sel), 32'd1);
        check_value("imm_sel", 32'(imm_sel), 32'(IMM_NONE));
        check_value("alu_sel", 32'(alu_sel), 32'(ALU_PASS_B));
        check_value("br_un", 32'(br_un), 32'd0);
        check_value("pc_sel", 32'(pc_sel), 32'd0);
        check_value("pc_exe", pc_exe, 32'd0);
        check_value("instr_exe", instr_exe, 32'd0);
        check_value("data_a_exe", data_a_exe, 32'd0);
        check_value("data_b_exe", data_b_exe, 32'd0);
    endtask

    task automatic compare_outputs();
        check_value("a_sel", 32'(a_sel), 32'(exp_ctl[10]));
        check_value("b_sel", 32'(b_sel), 32'(exp_ctl[9]));
        check_value("imm_sel", 32'(imm_sel), 32'(exp_ctl[8:5]));
        check_value("alu_sel", 32'(alu_sel), 32'(exp_ctl[4:1]));
        check_value("br_un", 32'(br_un), 32'(exp_ctl[0]));
        check_value("pc_sel", 32'(pc_sel), 32'(exp_take));
        check_value("pc_exe", pc_exe, exp_pc);
        check_value("instr_exe", instr_exe, exp_instr);
        check_value("data_a_exe", data_a_exe, exp_a);
        check_value("data_b_exe", data_b_exe, exp_b);
    endtask

    // Drives one instruction and checks the one driven a cycle before
    task automatic step(input word_t instr, input word_t pc_val, input word_t a, input word_t b);
        @(posedge clk);
        instruction <= instr;
        pc <= pc_val;
        data_a <= a;
        data_b <= b;
        @(negedge clk);
        if (have_prev) compare_outputs();
        exp_ctl = decode_model(instr);
        exp_take = branch_model(instr, a, b);
        exp_pc = pc_val;
        exp_instr = instr;
        exp_a = a;
        exp_b = b;
        have_prev = 1'b1;
    endtask

    task automatic flush();
        @(posedge clk);
        @(negedge clk);
        if (have_prev) compare_outputs();
        have_prev = 1'b0;
    endtask

    task automatic run_batch(input int kind, input int count);
        word_t instr;
        word_t a;
        word_t b;
        for (int i = 0; i < count; i++) begin
            case (kind)
                2:       instr = gen_arith();
                3:       instr = gen_fixed();
                4:       instr = gen_branch();
                5:       instr = gen_undef();
                default: instr = gen_mixed();
            endcase
            pick_operands(kind == 4, a, b);
            step(instr, pc_now, a, b);
            pc_now = pc_now + 32'd4;
        end
        flush();
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = error_count - errors_at_start;
        test_num++;
        if (errs == 0) begin
            $display("Test %0d (%s) done with no errors", test_num, name);
        end else begin
            tests_failed++;
            $display("Test %0d (%s) done with %0d errors", test_num, name, errs);
        end
        errors_at_start = error_count;
    endtask

    initial begin
        instruction <= '0;
        pc <= '0;
        data_a <= '0;
        data_b <= '0;
        pc_now = next_rand() & 32'hffff_fffc;

        @(negedge clk);
        check_reset_outputs();
        while (rst) begin
            @(negedge clk);
        end
        // Reset released, no active edge seen yet
        check_reset_outputs();
        finish_test("reset values");

        run_batch(2, N_ARITH);
        finish_test("OP and OP-IMM decode");
        run_batch(3, N_FIXED);
        finish_test("loads, stores, LUI, AUIPC, JAL and JALR");
        run_batch(4, N_BRANCH);
        finish_test("branch resolution");
        run_batch(5, N_UNDEF);
        finish_test("undefined encodings");
        run_batch(6, N_STREAM);
        finish_test("back-to-back pass-through");

        assert_fails = i_execute_ctl.i_execute_ctl_assertions.fail_count;
        $display("Tests run: %0d, tests failed: %0d, checks: %0d, errors: %0d, %s: %0d",
                 test_num, tests_failed, check_count, error_count,
                 "assertion failures", assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* exe_ctl.f */
hdl/exe_pkg.sv
hdl/exe_decoder.sv
hdl/branch_unit.sv
hdl/execute_ctl.sv
testbench/tb_clock.sv
testbench/execute_ctl_assertions.sv
testbench/execute_ctl_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= execute_ctl_tb
FILELIST  ?= exe_ctl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
